//--- compile.f
+incdir+include
hdl/muldiv_pkg.sv
hdl/muldiv_decode.sv
hdl/mul_exec.sv
hdl/div_exec.sv
hdl/muldiv_result.sv
hdl/muldiv_top.sv
verif/tb_muldiv.sv

//--- run.sh
#!/bin/sh
# build the muldiv testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_muldiv -f compile.f -o tb_muldiv > build.log 2>&1 || \
    { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_muldiv > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0

//--- verif/muldiv_golden.txt
# instr    src1     src2     rslt_o   (rslt_o none: no done_o expected)
# all values hex, one operation per line
02C58533 00000007 00000006 0000002A
02C58533 00001234 00005678 06260060
02C58533 FFFFFFFF FFFFFFFF 00000001
02C59533 FFFFFFFF FFFFFFFF 00000000
02C5B533 FFFFFFFF FFFFFFFF FFFFFFFE
02C5A533 FFFFFFFF FFFFFFFF FFFFFFFF
00C58533 00000005 00000003 none
02C59533 80000000 80000000 40000000
02C5B533 80000000 FFFFFFFF 7FFFFFFF
02C5A533 80000000 FFFFFFFF 80000000
02C59533 80000000 FFFFFFFF 00000000
02C58533 80000000 FFFFFFFF 80000000
02C5B533 00010000 00010000 00000001
02C59533 FFFFFFFE 00000003 FFFFFFFF
02C58533 FFFFFFFE 00000003 FFFFFFFA
02C5A533 00000002 FFFFFFFF 00000001
02C5C533 00000014 00000006 00000003
02C5C533 FFFFFFEC 00000006 FFFFFFFD
02C5C533 00000014 FFFFFFFA FFFFFFFD
02C5C533 FFFFFFEC FFFFFFFA 00000003
02C5E533 FFFFFFEC 00000006 FFFFFFFE
02C5E533 00000014 FFFFFFFA 00000002
02C5E533 FFFFFFEC FFFFFFFA FFFFFFFE
02C5D533 FFFFFFEC 00000006 2AAAAAA7
02C5F533 FFFFFFEC 00000006 00000002
40C58533 00000014 00000006 none
02C5D533 00000014 FFFFFFFA 00000000
02C5F533 00000014 FFFFFFFA 00000014
02C5D533 FFFFFFFF 00000001 FFFFFFFF
02C5E533 00000007 00000007 00000000
02C5C533 00000014 00000000 FFFFFFFF
02C5D533 12345678 00000000 FFFFFFFF
02C5E533 FFFFFFEC 00000000 FFFFFFEC
02C5F533 12345678 00000000 12345678
02C5C533 FFFFFFEC 00000000 FFFFFFFF
02C5C533 80000000 FFFFFFFF 80000000
02C5E533 80000000 FFFFFFFF 00000000
02C5853B 00000003 00000004 none
02C5C533 80000000 00000002 C0000000
02C5D533 80000000 00000002 40000000

//--- verif/tb_muldiv.sv
`timescale 1ns/1ps
`default_nettype none

module tb_muldiv;

    logic        clk_i;
    logic        rst;
    logic        valid_i;
    logic [31:0] instr_i;
    logic [31:0] src1_i;
    logic [31:0] src2_i;
    logic        busy_o;
    logic        done_o;
    logic [31:0] rslt_o;

    // one entry per golden line
    logic [31:0] instr_q[$];
    logic [31:0] src1_q[$];
    logic [31:0] src2_q[$];
    logic [31:0] expect_q[$];
    bit          has_done_q[$];       // 0 for lines marked none

    logic [31:0] lfsr;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;

    muldiv_top dut (
        .clk_i   (clk_i),
        .rst     (rst),
        .valid_i (valid_i),
        .instr_i (instr_i),
        .src1_i  (src1_i),
        .src2_i  (src2_i),
        .busy_o  (busy_o),
        .done_o  (done_o),
        .rslt_o  (rslt_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;   // 40 ns period
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_random(input int nbits, output int val);
        val = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_step(lfsr);           // one step per bit
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_on_error($sformatf("Error: %s is 0x%08h, expected 0x%08h",
                                    name, got, exp));
        end
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] w3;
        fd = $fopen("verif/muldiv_golden.txt", "r");
        if (fd == 0) begin
            stop_on_error("could not open verif/muldiv_golden.txt");
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%h %h %h %h", w0, w1, w2, w3);
            if (n >= 3) begin                 // comment lines give 0
                instr_q.push_back(w0);
                src1_q.push_back(w1);
                src2_q.push_back(w2);
                expect_q.push_back((n == 4) ? w3 : 32'h0);
                has_done_q.push_back(n == 4);
            end
        end
        $fclose(fd);
    endtask

    // ------------------------------------------------------------
    // one golden line
    // ------------------------------------------------------------
    task automatic run_op(input int idx);
        logic [31:0] instr;
        logic [31:0] src1;
        logic [31:0] src2;
        logic [31:0] prev_rslt;
        int          gap;
        int          pulse_at;
        int          edge_no;
        int          exp_edge;
        instr     = instr_q[idx];
        src1      = src1_q[idx];
        src2      = src2_q[idx];
        prev_rslt = rslt_o;
        take_random(2, gap);
        take_random(1, pulse_at);
        pulse_at = pulse_at + 2;              // busy pulse on edge 2 or 3
        repeat (gap) @(posedge clk_i);
        @(posedge clk_i);
        valid_i <= 1'b1;
        instr_i <= instr;
        src1_i  <= src1;
        src2_i  <= src2;
        @(posedge clk_i);                     // accept edge counts as edge 1
        valid_i <= 1'b0;
        if (!has_done_q[idx]) begin
            repeat (40) begin
                @(negedge clk_i);
                check_value("done_o", 32'(done_o), 32'h0);
                check_value("busy_o", 32'(busy_o), 32'h0);
            end
            check_value("rslt_o", rslt_o, prev_rslt);
        end else begin
            // divide by nonzero ends on edge 35 and the rest on edge 3
            exp_edge = (instr[14] && src2 != 32'h0) ? 35 : 3;
            edge_no  = 1;
            @(negedge clk_i);
            check_value("busy_o", 32'(busy_o), 32'h1);
            while (!done_o) begin
                @(posedge clk_i);
                edge_no++;
                if (edge_no == pulse_at) begin
                    valid_i <= 1'b1;          // must be ignored while busy
                    src1_i  <= ~src1;
                end else begin
                    valid_i <= 1'b0;
                end
                @(negedge clk_i);
                check_value("busy_o", 32'(busy_o), 32'h1);
            end
            check_value("done_o edge", edge_no, exp_edge);
            check_value("rslt_o", rslt_o, expect_q[idx]);
            @(posedge clk_i);
            valid_i <= 1'b0;
            @(negedge clk_i);
            check_value("done_o", 32'(done_o), 32'h0);   // single pulse
            check_value("busy_o", 32'(busy_o), 32'h0);
            check_value("rslt_o", rslt_o, expect_q[idx]);
        end
    endtask

    // run limit of 40 cycles per golden line plus slack
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            stop_on_error("timeout, the run went past its cycle limit");
        end
    end

    initial begin
        rst     = 1'b1;
        valid_i = 1'b0;
        instr_i = 32'h0;
        src1_i  = 32'h0;
        src2_i  = 32'h0;
        lfsr    = 32'ha5e7;
        load_golden();
        if (instr_q.size() == 0) begin
            stop_on_error("the golden file holds no operations");
        end
        cycle_limit = instr_q.size() * 40 + 100;
        repeat (3) @(posedge clk_i);
        rst <= 1'b0;
        @(negedge clk_i);
        check_value("done_o", 32'(done_o), 32'h0);
        check_value("busy_o", 32'(busy_o), 32'h0);
        check_value("rslt_o", rslt_o, 32'h0);
        for (int i = 0; i < instr_q.size(); i++) begin
            run_op(i);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/muldiv_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "muldiv_config.svh"

module muldiv_top import muldiv_pkg::*; (
    input  logic        clk_i,
    input  logic        rst,
    input  logic        valid_i,
    input  logic [31:0] instr_i,
    input  word_t       src1_i,
    input  word_t       src2_i,
    output logic        busy_o,
    output logic        done_o,
    output word_t       rslt_o
);

    logic       mul_start;
    logic       div_start;
    muldiv_op_t op;
    mul_out_t   mul_out;
    div_out_t   div_out;

    muldiv_decode u_decode (
        .clk_i       (clk_i),
        .rst         (rst),
        .valid_i     (valid_i),
        .instr_i     (instr_i),
        .src1_i      (src1_i),
        .src2_i      (src2_i),
        .done_i      (done_o),        // result done clears busy
        .busy_o      (busy_o),
        .mul_start_o (mul_start),
        .div_start_o (div_start),
        .op_o        (op)
    );

    mul_exec u_mul (
        .clk_i   (clk_i),
        .rst     (rst),
        .start_i (mul_start),
        .op_i    (op),
        .src1_i  (src1_i),
        .src2_i  (src2_i),
        .out_o   (mul_out)
    );

    div_exec u_div (
        .clk_i   (clk_i),
        .rst     (rst),
        .start_i (div_start),
        .op_i    (op),
        .src1_i  (src1_i),
        .src2_i  (src2_i),
        .out_o   (div_out)
    );

    muldiv_result u_result (
        .clk_i      (clk_i),
        .rst        (rst),
        .op_valid_i ({div_start, mul_start}),
        .op_i       (op),
        .mul_i      (mul_out),
        .div_i      (div_out),
        .done_o     (done_o),
        .rslt_o     (rslt_o)
    );

endmodule

`default_nettype wire

//--- hdl/muldiv_result.sv
`timescale 1ns/1ps
`default_nettype none
`include "muldiv_config.svh"

module muldiv_result import muldiv_pkg::*; (
    input  logic       clk_i,
    input  logic       rst,
    input  logic [1:0] op_valid_i,    // {div_start, mul_start}
    input  muldiv_op_t op_i,
    input  mul_out_t   mul_i,
    input  div_out_t   div_i,
    output logic       done_o,
    output word_t      rslt_o
);

    muldiv_op_t op_q;
    word_t      mul_rslt;
    word_t      div_sel;
    logic       div_neg;
    word_t      div_rslt;
    logic       done_q;
    word_t      rslt_q;

    always_ff @(posedge clk_i) begin
        if (|op_valid_i) begin
            op_q <= op_i;
        end
    end

    assign mul_rslt = op_q.is_high ? mul_i.product[2*`MULDIV_XLEN-1:`MULDIV_XLEN]
                                   : mul_i.product[`MULDIV_XLEN-1:0];

    // sign fix-up, all-ones quotient of a zero divisor stays as is
    assign div_sel  = op_q.is_rem ? div_i.rem : div_i.quot;
    assign div_neg  = op_q.is_rem ? op_q.neg_rem : (op_q.neg_quot && !div_i.by_zero);
    assign div_rslt = div_neg ? ~div_sel + 1'b1 : div_sel;

    always_ff @(posedge clk_i) begin
        if (rst) begin
            done_q <= 1'b0;
            rslt_q <= '0;
        end else begin
            done_q <= mul_i.done || div_i.done;
            if (mul_i.done || div_i.done) begin
                rslt_q <= op_q.is_div ? div_rslt : mul_rslt;   // held until next done
            end
        end
    end

    assign done_o = done_q;
    assign rslt_o = rslt_q;

endmodule

`default_nettype wire

//--- hdl/div_exec.sv
`timescale 1ns/1ps
`default_nettype none
`include "muldiv_config.svh"

module div_exec import muldiv_pkg::*; (
    input  logic       clk_i,
    input  logic       rst,
    input  logic       start_i,
    input  muldiv_op_t op_i,
    input  word_t      src1_i,
    input  word_t      src2_i,
    output div_out_t   out_o
);

    localparam int CNT_W = $clog2(`MULDIV_DIV_STEPS);

    div_state_e               state;
    div_state_e               state_nxt;
    word_t                    src1_mag;
    word_t                    src2_mag;
    word_t                    dvsr_q;
    word_t                    rem_q;
    word_t                    quot_q;      // dividend shifts out, quotient shifts in
    logic                     by_zero_q;
    logic [CNT_W-1:0]         cnt_q;
    logic [`MULDIV_XLEN:0]    shifted;     // partial remainder with next dividend bit
    logic [`MULDIV_XLEN+1:0]  diff;
    logic                     q_bit;

    // magnitudes of signed operands
    assign src1_mag = (op_i.src1_signed && src1_i[`MULDIV_XLEN-1]) ? ~src1_i + 1'b1 : src1_i;
    assign src2_mag = (op_i.src2_signed && src2_i[`MULDIV_XLEN-1]) ? ~src2_i + 1'b1 : src2_i;

    assign shifted = {rem_q, quot_q[`MULDIV_XLEN-1]};
    assign diff    = {1'b0, shifted} - {2'b00, dvsr_q};
    assign q_bit   = !diff[`MULDIV_XLEN+1];     // no borrow, subtract sticks

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            DIV_IDLE:  if (start_i) state_nxt = DIV_CHECK;
            DIV_CHECK: state_nxt = (dvsr_q == '0) ? DIV_RET : DIV_EXEC;
            DIV_EXEC:  if (cnt_q == '0) state_nxt = DIV_RET;
            default:   state_nxt = DIV_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst) begin
            state <= DIV_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ------------------------------------------------------------
    // restoring shift-subtract datapath
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        case (state)
            DIV_IDLE: begin
                if (start_i) begin
                    quot_q <= src1_mag;
                    dvsr_q <= src2_mag;
                    rem_q  <= '0;
                end
            end
            DIV_CHECK: begin
                by_zero_q <= (dvsr_q == '0);
                cnt_q     <= CNT_W'(`MULDIV_DIV_STEPS - 1);
                if (dvsr_q == '0) begin
                    rem_q  <= quot_q;           // remainder is the dividend
                    quot_q <= '1;
                end
            end
            DIV_EXEC: begin
                cnt_q  <= cnt_q - 1'b1;
                rem_q  <= q_bit ? diff[`MULDIV_XLEN-1:0] : shifted[`MULDIV_XLEN-1:0];
                quot_q <= {quot_q[`MULDIV_XLEN-2:0], q_bit};
            end
            default: begin
            end
        endcase
    end

    assign out_o.done    = (state == DIV_RET);
    assign out_o.by_zero = by_zero_q;
    assign out_o.quot    = quot_q;
    assign out_o.rem     = rem_q;

endmodule

`default_nettype wire

//--- hdl/mul_exec.sv
`timescale 1ns/1ps
`default_nettype none
`include "muldiv_config.svh"

module mul_exec import muldiv_pkg::*; (
    input  logic       clk_i,
    input  logic       rst,
    input  logic       start_i,
    input  muldiv_op_t op_i,
    input  word_t      src1_i,
    input  word_t      src2_i,
    output mul_out_t   out_o
);

    mul_state_e                    state;
    logic signed [`MULDIV_XLEN:0]  mcand_q;     // 33 bit, sign or zero extended
    logic signed [`MULDIV_XLEN:0]  mplier_q;
    logic signed [2*`MULDIV_XLEN+1:0] full_prod;
    dword_t                        product_q;

    assign full_prod = mcand_q * mplier_q;

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst) begin
            state <= MUL_IDLE;
        end else begin
            case (state)
                MUL_IDLE: if (start_i) state <= MUL_EXEC;
                MUL_EXEC: state <= MUL_RET;
                default:  state <= MUL_IDLE;    // ret lasts one cycle
            endcase
        end
    end

    // ------------------------------------------------------------
    // datapath
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (state == MUL_IDLE && start_i) begin
            mcand_q  <= {op_i.src1_signed && src1_i[`MULDIV_XLEN-1], src1_i};
            mplier_q <= {op_i.src2_signed && src2_i[`MULDIV_XLEN-1], src2_i};
        end
        if (state == MUL_EXEC) begin
            product_q <= full_prod[2*`MULDIV_XLEN-1:0];
        end
    end

    assign out_o.done    = (state == MUL_RET);
    assign out_o.product = product_q;

endmodule

`default_nettype wire

//--- hdl/muldiv_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "muldiv_config.svh"

module muldiv_decode import muldiv_pkg::*; (
    input  logic        clk_i,
    input  logic        rst,
    input  logic        valid_i,
    input  logic [31:0] instr_i,
    input  word_t       src1_i,
    input  word_t       src2_i,
    input  logic        done_i,
    output logic        busy_o,
    output logic        mul_start_o,
    output logic        div_start_o,
    output muldiv_op_t  op_o
);

    funct3_t funct3;
    logic    is_m;
    logic    accept;
    logic    s1_signed;
    logic    s2_signed;
    logic    busy_q;

    assign funct3 = instr_i[14:12];
    assign is_m   = (instr_i[6:0] == `MULDIV_OPCODE_OP) &&
                    (instr_i[31:25] == `MULDIV_FUNCT7);
    assign accept = valid_i && !busy_q && is_m;    // requests while busy are dropped

    assign mul_start_o = accept && !funct3[2];
    assign div_start_o = accept && funct3[2];

    // MULH, MULHSU, DIV and REM read src1 as signed; MULH, DIV and REM also src2
    assign s1_signed = (funct3 == 3'b001) || (funct3 == 3'b010) ||
                       (funct3 == 3'b100) || (funct3 == 3'b110);
    assign s2_signed = (funct3 == 3'b001) || (funct3 == 3'b100) || (funct3 == 3'b110);

    always_comb begin
        op_o.is_div      = funct3[2];
        op_o.src1_signed = s1_signed;
        op_o.src2_signed = s2_signed;
        op_o.is_high     = !funct3[2] && (funct3[1:0] != 2'b00);   // MUL keeps low half
        op_o.is_rem      = funct3[2] && funct3[1];
        op_o.neg_quot    = funct3[2] && s1_signed &&
                           (src1_i[`MULDIV_XLEN-1] ^ src2_i[`MULDIV_XLEN-1]);
        op_o.neg_rem     = funct3[2] && s1_signed && src1_i[`MULDIV_XLEN-1];
    end

    // busy from start until the result module reports done
    always_ff @(posedge clk_i) begin
        if (rst) begin
            busy_q <= 1'b0;
        end else if (mul_start_o || div_start_o) begin
            busy_q <= 1'b1;
        end else if (done_i) begin
            busy_q <= 1'b0;
        end
    end

    assign busy_o = busy_q;

endmodule

`default_nettype wire

//--- hdl/muldiv_pkg.sv
`default_nettype none
`include "muldiv_config.svh"

package muldiv_pkg;

    // ------------------------------------------------------------
    // width types
    // ------------------------------------------------------------
    typedef logic [`MULDIV_XLEN-1:0]   word_t;
    typedef logic [2*`MULDIV_XLEN-1:0] dword_t;
    typedef logic [2:0]                funct3_t;

    // ------------------------------------------------------------
    // state machines
    // ------------------------------------------------------------
    typedef enum logic [1:0] {MUL_IDLE, MUL_EXEC, MUL_RET} mul_state_e;
    typedef enum logic [1:0] {DIV_IDLE, DIV_CHECK, DIV_EXEC, DIV_RET} div_state_e;

    // ------------------------------------------------------------
    // inter-module bundles
    // ------------------------------------------------------------
    typedef struct packed {
        logic is_div;       // DIV/DIVU/REM/REMU
        logic src1_signed;
        logic src2_signed;
        logic is_high;      // upper half of the product
        logic is_rem;
        logic neg_quot;     // operand signs differ
        logic neg_rem;      // dividend negative
    } muldiv_op_t;

    typedef struct packed {
        logic   done;
        dword_t product;
    } mul_out_t;

    typedef struct packed {
        logic  done;
        logic  by_zero;
        word_t quot;        // unsigned magnitudes
        word_t rem;
    } div_out_t;

endpackage

`default_nettype wire

//--- include/muldiv_config.svh
`ifndef MULDIV_CONFIG_SVH
`define MULDIV_CONFIG_SVH

// operand and result width
`define MULDIV_XLEN 32

// OP major opcode and the funct7 of the M extension
`define MULDIV_OPCODE_OP 7'b0110011
`define MULDIV_FUNCT7 7'b0000001

// one quotient bit per step
`define MULDIV_DIV_STEPS `MULDIV_XLEN

`endif
